// File: logic/core_settings.svh
// fixed for three rv32 ways; only add, sub, addi, beq and wfi decode as legal
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_WAYS 3   // ways per bundle
`define CORE_XLEN 32
`define CORE_REGS 32

// major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_BRANCH 7'b1100011
`define OPC_SYSTEM 7'b1110011

`define FUNCT3_ADD 3'b000
`define FUNCT3_BEQ 3'b000
`define FUNCT_SUB  30             // instruction bit that turns add into sub
`define WFI_WORD   32'h10500073
`define NOP_WORD   32'h00000013   // addi x0, x0, 0

`endif

// File: logic/core_pkg.sv
// per-way vectors keep way 0 in the low bits and widths follow core_settings.svh
`include "core_settings.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [`CORE_XLEN-1:0] addr_t;
	typedef logic [$clog2(`CORE_REGS)-1:0] reg_idx_t;
	typedef logic [31:0] inst_t;

	// three instruction words as one fetch
	typedef logic [`CORE_WAYS*32-1:0] bundle_t;

	typedef logic [`CORE_WAYS-1:0] way_mask_t;     // one bit per way
	typedef logic [$clog2(`CORE_WAYS+1)-1:0] count_t;  // zero to three ways

	////////////////////////////////////////
	// enums

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_EQ     // compare for beq
	} alu_op_e;

	// sticky once set
	typedef enum logic [1:0] {
		NO_ERROR,
		HALTED_ON_WFI,
		ILLEGAL_INST
	} status_e;

endpackage

// File: logic/fetch_unit.sv
// bundle must come back in the same cycle as fetch_addr; fetch never stalls
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  core_pkg::bundle_t     fetch_bundle,   // words at pc, pc+4, pc+8
	input  logic                  redirect,
	input  core_pkg::addr_t       redirect_pc,
	input  logic                  halted,
	output core_pkg::addr_t       fetch_addr,
	output core_pkg::bundle_t     fd_bundle,
	output core_pkg::addr_t [2:0] fd_pc,
	output core_pkg::way_mask_t   fd_valid
);
	import core_pkg::*;

	addr_t       pc;
	inst_t [2:0] word;
	way_mask_t   keep;
	count_t      kept;

	// destination of an alu instruction or zero when nothing is written
	function automatic reg_idx_t dest_of(inst_t inst);
		reg_idx_t rd;
		rd = '0;
		if (inst[6:0] == `OPC_OP || inst[6:0] == `OPC_OP_IMM)
			rd = inst[11:7];
		return rd;
	endfunction

	function automatic logic reads(inst_t inst, reg_idx_t idx);
		logic use_rs1;
		logic use_rs2;
		use_rs2 = inst[6:0] == `OPC_OP || inst[6:0] == `OPC_BRANCH;
		use_rs1 = use_rs2 || inst[6:0] == `OPC_OP_IMM;
		return idx != '0
			&& ((use_rs1 && inst[19:15] == idx) || (use_rs2 && inst[24:20] == idx));
	endfunction

	assign word       = fetch_bundle;
	assign fetch_addr = pc;

	// a way reading an older way's result waits for the next bundle
	always_comb begin
		keep[0] = 1'b1;
		keep[1] = !reads(word[1], dest_of(word[0]));
		keep[2] = keep[1] && !reads(word[2], dest_of(word[0]))
			&& !reads(word[2], dest_of(word[1]));
		kept = keep[2] ? 2'd3 : (keep[1] ? 2'd2 : 2'd1);
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			pc       <= '0;
			fd_valid <= '0;
		end else if (redirect) begin
			pc       <= redirect_pc;
			fd_valid <= '0;    // wrong path
		end else if (halted) begin
			fd_valid <= '0;    // pc stays put
		end else begin
			pc       <= pc + (addr_t'(kept) << 2);
			fd_valid <= keep;
		end
	end

	// dropped ways carry a nop
	always_ff @(posedge clock) begin
		for (int i = 0; i < 3; i++) begin
			fd_bundle[i*32 +: 32] <= keep[i] ? word[i] : `NOP_WORD;
			fd_pc[i]              <= pc + addr_t'(4 * i);
		end
	end

endmodule

// File: logic/register_file.sv
// reset clears every register; a commit write shows on the read ports in its own cycle
`timescale 1ns/1ps
`include "core_settings.svh"

module register_file (
	input  logic                     clock,
	input  logic                     reset,
	input  core_pkg::reg_idx_t [5:0] rd_idx,   // way i uses ports 2i and 2i+1
	input  core_pkg::way_mask_t      wr_en,
	input  core_pkg::reg_idx_t [2:0] wr_idx,
	input  core_pkg::word_t [2:0]    wr_data,
	output core_pkg::word_t [5:0]    rd_data
);
	import core_pkg::*;

	word_t regs [`CORE_REGS];

	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int r = 0; r < `CORE_REGS; r++)
				regs[r] <= '0;
		end else begin
			for (int w = 0; w < 3; w++)    // higher way lands last
				if (wr_en[w] && wr_idx[w] != '0)
					regs[wr_idx[w]] <= wr_data[w];
		end
	end

	// write-through lets decode see the bundle now committing
	always_comb begin
		for (int p = 0; p < 6; p++) begin
			rd_data[p] = regs[rd_idx[p]];
			for (int w = 0; w < 3; w++)
				if (wr_en[w] && wr_idx[w] == rd_idx[p])
					rd_data[p] = wr_data[w];
			if (rd_idx[p] == '0)
				rd_data[p] = '0;    // x0 hardwired
		end
	end

endmodule

// File: logic/decode_unit.sv
// decodes only add, sub, addi, beq and wfi; anything else is flagged illegal
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_unit (
	input  logic                     clock,
	input  logic                     reset,
	input  core_pkg::bundle_t        fd_bundle,
	input  core_pkg::addr_t [2:0]    fd_pc,
	input  core_pkg::way_mask_t      fd_valid,
	input  logic                     redirect,
	input  core_pkg::way_mask_t      commit_wr_en,
	input  core_pkg::reg_idx_t [2:0] commit_wr_idx,
	input  core_pkg::word_t [2:0]    commit_wr_data,
	output core_pkg::word_t [2:0]    de_rs1_val,
	output core_pkg::word_t [2:0]    de_rs2_val,
	output core_pkg::reg_idx_t [2:0] de_rs1_idx,
	output core_pkg::reg_idx_t [2:0] de_rs2_idx,
	output core_pkg::reg_idx_t [2:0] de_rd_idx,
	output core_pkg::word_t [2:0]    de_imm,
	output core_pkg::alu_op_e [2:0]  de_alu_op,
	output core_pkg::way_mask_t      de_use_imm,
	output core_pkg::way_mask_t      de_writes,
	output core_pkg::way_mask_t      de_branch,
	output core_pkg::way_mask_t      de_halt,
	output core_pkg::way_mask_t      de_illegal,
	output core_pkg::addr_t [2:0]    de_pc,
	output core_pkg::way_mask_t      de_valid
);
	import core_pkg::*;

	inst_t [2:0]    inst;
	reg_idx_t [5:0] rd_idx;
	word_t [5:0]    rd_data;
	word_t [2:0]    imm;
	alu_op_e [2:0]  alu_op;
	way_mask_t      use_imm;
	way_mask_t      writes;
	way_mask_t      branch;
	way_mask_t      halt;
	way_mask_t      illegal;

	assign inst = fd_bundle;

	////////////////////////////////////////
	// per-way decode
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			alu_op[i]  = ALU_ADD;
			use_imm[i] = 1'b0;
			writes[i]  = 1'b0;
			branch[i]  = 1'b0;
			halt[i]    = 1'b0;
			illegal[i] = 1'b0;
			imm[i]     = {{20{inst[i][31]}}, inst[i][31:20]};    // i form
			case (inst[i][6:0])
				`OPC_OP: begin
					if (inst[i][14:12] == `FUNCT3_ADD
						&& inst[i][31:25] == {1'b0, inst[i][`FUNCT_SUB], 5'b0}) begin
						alu_op[i] = inst[i][`FUNCT_SUB] ? ALU_SUB : ALU_ADD;
						writes[i] = inst[i][11:7] != '0;
					end else begin
						illegal[i] = 1'b1;
					end
				end
				`OPC_OP_IMM: begin
					use_imm[i] = 1'b1;
					if (inst[i][14:12] == `FUNCT3_ADD)
						writes[i] = inst[i][11:7] != '0;
					else
						illegal[i] = 1'b1;
				end
				`OPC_BRANCH: begin
					alu_op[i]  = ALU_EQ;
					branch[i]  = inst[i][14:12] == `FUNCT3_BEQ;
					illegal[i] = inst[i][14:12] != `FUNCT3_BEQ;
					imm[i]     = {{20{inst[i][31]}}, inst[i][7], inst[i][30:25],
						inst[i][11:8], 1'b0};    // b form
				end
				`OPC_SYSTEM: begin
					halt[i]    = inst[i] == `WFI_WORD;
					illegal[i] = inst[i] != `WFI_WORD;
				end
				default: illegal[i] = 1'b1;
			endcase
			rd_idx[2*i]   = inst[i][19:15];
			rd_idx[2*i+1] = inst[i][24:20];    // garbage for addi and unused there
		end
	end

	register_file register_file_i (
		.clock   (clock),
		.reset   (reset),
		.rd_idx  (rd_idx),
		.wr_en   (commit_wr_en),
		.wr_idx  (commit_wr_idx),
		.wr_data (commit_wr_data),
		.rd_data (rd_data)
	);

	////////////////////////////////////////
	// decode to execute register
	always_ff @(posedge clock) begin
		if (!reset || redirect)
			de_valid <= '0;
		else
			de_valid <= fd_valid;
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < 3; i++) begin
			de_rs1_val[i] <= rd_data[2*i];
			de_rs2_val[i] <= rd_data[2*i+1];
			de_rs1_idx[i] <= rd_idx[2*i];
			de_rs2_idx[i] <= rd_idx[2*i+1];
			de_rd_idx[i]  <= inst[i][11:7];
		end
		de_imm     <= imm;
		de_alu_op  <= alu_op;
		de_use_imm <= use_imm;
		de_writes  <= writes;
		de_branch  <= branch;
		de_halt    <= halt;
		de_illegal <= illegal;
		de_pc      <= fd_pc;
	end

endmodule

// File: logic/execute_unit.sv
// forwarding reaches only the bundle in the commit register; older results come from decode
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_unit (
	input  logic                     clock,
	input  logic                     reset,
	input  core_pkg::word_t [2:0]    de_rs1_val,
	input  core_pkg::word_t [2:0]    de_rs2_val,
	input  core_pkg::reg_idx_t [2:0] de_rs1_idx,
	input  core_pkg::reg_idx_t [2:0] de_rs2_idx,
	input  core_pkg::reg_idx_t [2:0] de_rd_idx,
	input  core_pkg::word_t [2:0]    de_imm,
	input  core_pkg::alu_op_e [2:0]  de_alu_op,
	input  core_pkg::way_mask_t      de_use_imm,
	input  core_pkg::way_mask_t      de_writes,
	input  core_pkg::way_mask_t      de_branch,
	input  core_pkg::way_mask_t      de_halt,
	input  core_pkg::way_mask_t      de_illegal,
	input  core_pkg::addr_t [2:0]    de_pc,
	input  core_pkg::way_mask_t      de_valid,
	output logic                     redirect,       // one-cycle pulse
	output core_pkg::addr_t          redirect_pc,
	output logic                     halted,
	output core_pkg::way_mask_t      commit_valid,
	output core_pkg::way_mask_t      commit_wr_en,
	output core_pkg::reg_idx_t [2:0] commit_wr_idx,
	output core_pkg::word_t [2:0]    commit_wr_data,
	output core_pkg::addr_t [2:0]    commit_pc,
	output core_pkg::count_t         completed_insts,
	output core_pkg::status_e        error_status
);
	import core_pkg::*;

	word_t [2:0] opa;
	word_t [2:0] opb;
	word_t [2:0] result;
	way_mask_t   taken;
	way_mask_t   stop;          // way ends the bundle
	way_mask_t   commit_next;
	addr_t       target;
	count_t      count_next;

	// newest committed value where the highest way wins
	function automatic word_t forward(reg_idx_t idx, word_t val);
		word_t v;
		v = val;
		for (int w = 0; w < `CORE_WAYS; w++)
			if (commit_wr_en[w] && commit_wr_idx[w] == idx)
				v = commit_wr_data[w];
		return v;
	endfunction

	////////////////////////////////////////
	// operands and alus
	always_comb begin
		for (int i = 0; i < `CORE_WAYS; i++) begin
			opa[i] = forward(de_rs1_idx[i], de_rs1_val[i]);
			opb[i] = de_use_imm[i] ? de_imm[i] : forward(de_rs2_idx[i], de_rs2_val[i]);
			case (de_alu_op[i])
				ALU_SUB: result[i] = opa[i] - opb[i];
				ALU_EQ:  result[i] = word_t'(opa[i] == opb[i]);
				default: result[i] = opa[i] + opb[i];
			endcase
			taken[i] = de_branch[i] && result[i][0];
			stop[i]  = de_valid[i] && (taken[i] || de_halt[i] || de_illegal[i]);
		end
	end

	// ways younger than a taken branch, wfi or illegal op are dropped
	always_comb begin
		commit_next[0] = de_valid[0];
		commit_next[1] = de_valid[1] && !stop[0];
		commit_next[2] = de_valid[2] && !stop[0] && !stop[1];
		if (redirect || halted)
			commit_next = '0;    // wrong path or core stopped
		target = '0;
		for (int i = `CORE_WAYS - 1; i >= 0; i--)
			if (commit_next[i] && taken[i])
				target = de_pc[i] + de_imm[i];
		count_next = '0;
		for (int i = 0; i < `CORE_WAYS; i++)
			count_next = count_next + count_t'(commit_next[i]);
	end

	////////////////////////////////////////
	// commit register
	always_ff @(posedge clock) begin
		if (!reset) begin
			commit_valid    <= '0;
			commit_wr_en    <= '0;
			completed_insts <= '0;
			redirect        <= 1'b0;
			halted          <= 1'b0;
			error_status    <= NO_ERROR;
		end else begin
			commit_valid    <= commit_next;
			commit_wr_en    <= commit_next & de_writes;
			completed_insts <= count_next;
			redirect        <= |(commit_next & taken);
			halted          <= halted || |(commit_next & (de_halt | de_illegal));
			if (|(commit_next & de_illegal))
				error_status <= ILLEGAL_INST;    // beats halt
			else if (|(commit_next & de_halt))
				error_status <= HALTED_ON_WFI;
		end
	end

	always_ff @(posedge clock) begin
		commit_wr_idx  <= de_rd_idx;
		commit_wr_data <= result;
		commit_pc      <= de_pc;
		redirect_pc    <= target;
	end

endmodule

// File: logic/superscalar_core.sv
// no stall and no handshake; fetch_bundle must answer fetch_addr in the same cycle
`timescale 1ns/1ps

module superscalar_core (
	input  logic                     clock,
	input  logic                     reset,
	input  core_pkg::bundle_t        fetch_bundle,
	output core_pkg::addr_t          fetch_addr,
	output core_pkg::way_mask_t      commit_valid,
	output core_pkg::way_mask_t      commit_wr_en,
	output core_pkg::reg_idx_t [2:0] commit_wr_idx,
	output core_pkg::word_t [2:0]    commit_wr_data,
	output core_pkg::addr_t [2:0]    commit_pc,
	output core_pkg::count_t         completed_insts,
	output core_pkg::status_e        error_status
);
	import core_pkg::*;

	// fetch to decode
	bundle_t     fd_bundle;
	addr_t [2:0] fd_pc;
	way_mask_t   fd_valid;

	// decode to execute
	word_t [2:0]    de_rs1_val;
	word_t [2:0]    de_rs2_val;
	reg_idx_t [2:0] de_rs1_idx;
	reg_idx_t [2:0] de_rs2_idx;
	reg_idx_t [2:0] de_rd_idx;
	word_t [2:0]    de_imm;
	alu_op_e [2:0]  de_alu_op;
	addr_t [2:0]    de_pc;
	way_mask_t      de_use_imm;
	way_mask_t      de_writes;
	way_mask_t      de_branch;
	way_mask_t      de_halt;
	way_mask_t      de_illegal;
	way_mask_t      de_valid;

	// execute back to fetch and decode
	logic  redirect;
	addr_t redirect_pc;
	logic  halted;

	fetch_unit   fetch_unit_i   (.*);
	decode_unit  decode_unit_i  (.*);
	execute_unit execute_unit_i (.*);

endmodule

// File: tb/core_assertions.sv
// watches the commit ports of superscalar_core through bind; way 0 is the oldest way
`timescale 1ns/1ps

module core_assertions (
	input logic                     clock,
	input logic                     reset,
	input core_pkg::way_mask_t      commit_valid,
	input core_pkg::way_mask_t      commit_wr_en,
	input core_pkg::reg_idx_t [2:0] commit_wr_idx,
	input core_pkg::count_t         completed_insts,
	input core_pkg::status_e        error_status
);
	import core_pkg::*;

	int   failures;    // running total of assertion failures
	logic x0_write;

	always_comb begin
		x0_write = 1'b0;
		for (int w = 0; w < 3; w++)
			if (commit_wr_en[w] && commit_wr_idx[w] == '0)
				x0_write = 1'b1;
	end

	////////////////////////////////////////
	// commit port rules

	wr_en_needs_valid: assert property (@(posedge clock) disable iff (!reset)
		(commit_wr_en & ~commit_valid) == '0)
		else begin
			$error("write enable on a way that does not commit");
			failures++;
		end

	no_x0_write: assert property (@(posedge clock) disable iff (!reset) !x0_write)
		else begin
			$error("commit writes register zero");
			failures++;
		end

	count_matches: assert property (@(posedge clock) disable iff (!reset)
		int'(completed_insts) == $countones(commit_valid))
		else begin
			$error("completed_insts differs from the number of committing ways");
			failures++;
		end

	// older ways commit first
	valid_in_order: assert property (@(posedge clock) disable iff (!reset)
		commit_valid inside {3'b000, 3'b001, 3'b011, 3'b111})
		else begin
			$error("a valid commit way sits above an invalid one");
			failures++;
		end

	status_sticky: assert property (@(posedge clock) disable iff (!reset)
		error_status != NO_ERROR |=> error_status != NO_ERROR)
		else begin
			$error("error_status went back to no error without reset");
			failures++;
		end

	quiet_after_reset: assert property (@(posedge clock)
		$rose(reset) |=> commit_valid == '0 && error_status == NO_ERROR)
		else begin
			$error("core not quiet right after reset release");
			failures++;
		end

endmodule

// File: tb/core_tb.sv
// programs must fit in 256 words and end in wfi or an illegal word; one core, reset before each test
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;
	import core_pkg::*;

	localparam int MEM_WORDS       = 256;
	localparam int RANDOM_OPS      = 16;
	localparam int TOTAL_INSTS     = 80;    // bound on all programs together
	localparam int TEST_COUNT      = 6;
	localparam int WATCHDOG_CYCLES = TOTAL_INSTS * 4 + TEST_COUNT * 40 + 100;

	logic           clock;
	logic           reset;
	bundle_t        fetch_bundle;
	addr_t          fetch_addr;
	way_mask_t      commit_valid;
	way_mask_t      commit_wr_en;
	reg_idx_t [2:0] commit_wr_idx;
	word_t [2:0]    commit_wr_data;
	addr_t [2:0]    commit_pc;
	count_t         completed_insts;
	status_e        error_status;

	inst_t    mem [MEM_WORDS];
	inst_t    prog [$];
	addr_t    exp_pc [$];    // commit stream of the model with the oldest first
	logic     exp_wen [$];
	reg_idx_t exp_idx [$];
	word_t    exp_data [$];
	int       test_errors;
	int       errors;
	int       failed_tests;

	superscalar_core superscalar_core_i (.*);

	bind superscalar_core core_assertions core_assertions_i (
		.clock           (clock),
		.reset           (reset),
		.commit_valid    (commit_valid),
		.commit_wr_en    (commit_wr_en),
		.commit_wr_idx   (commit_wr_idx),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * 8);
		$display("watchdog expired, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	////////////////////////////////////////
	// instruction memory and encoders

	function automatic inst_t word_at(addr_t addr);
		return mem[addr[9:2]];
	endfunction

	always_comb begin
		for (int i = 0; i < 3; i++)
			fetch_bundle[i*32 +: 32] = word_at(fetch_addr + addr_t'(4 * i));    // way 0 lowest
	end

	function automatic inst_t op_inst(int funct7, int rd, int rs1, int rs2);
		return {7'(funct7), 5'(rs2), 5'(rs1), 3'b000, 5'(rd), `OPC_OP};
	endfunction

	function automatic inst_t addi_inst(int rd, int rs1, int imm);
		return {12'(imm), 5'(rs1), 3'b000, 5'(rd), `OPC_OP_IMM};
	endfunction

	function automatic inst_t beq_inst(int rs1, int rs2, int offset);
		logic [12:0] b;
		b = 13'(offset);
		return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'b000, b[4:1], b[11], `OPC_BRANCH};
	endfunction

	// fill words end in 00 so no opcode there is legal
	task automatic load_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (i < prog.size()) ? prog[i] : inst_t'(32'hbad0_0000 + 4 * i);
	endtask

	task automatic build_program(int id);
		int rd;
		int rs1;
		int rs2;
		prog.delete();
		case (id)
			1: begin
				for (int r = 8; r < 16; r++)    // sources live in x8..x15
					prog.push_back(addi_inst(r, 0, int'($urandom_range(4095)) - 2048));
				for (int n = 0; n < RANDOM_OPS; n++) begin
					rd  = int'($urandom_range(7));
					rs1 = 8 + int'($urandom_range(7));
					rs2 = 8 + int'($urandom_range(7));
					case ($urandom_range(2))
						0: prog.push_back(op_inst(0, rd, rs1, rs2));
						1: prog.push_back(op_inst(32, rd, rs1, rs2));
						default: prog.push_back(addi_inst(rd, rs1, int'($urandom_range(4095)) - 2048));
					endcase
				end
			end
			2: begin
				prog.push_back(addi_inst(1, 0, 5));
				prog.push_back(addi_inst(2, 1, 3));    // forwarded from commit
				prog.push_back(op_inst(0, 3, 1, 2));   // x1 by write-through
				prog.push_back(op_inst(32, 4, 3, 1));
				prog.push_back(addi_inst(4, 4, -100));
				prog.push_back(op_inst(0, 5, 4, 3));
				prog.push_back(addi_inst(6, 0, 1));
				prog.push_back(addi_inst(6, 0, 2));    // same bundle where the higher way wins
				prog.push_back(op_inst(0, 7, 6, 5));
				prog.push_back(op_inst(32, 1, 7, 6));
				prog.push_back(op_inst(0, 2, 1, 1));
			end
			3: begin
				prog.push_back(addi_inst(1, 0, 7));
				prog.push_back(addi_inst(2, 0, 7));
				prog.push_back(addi_inst(3, 0, 9));
				prog.push_back(beq_inst(1, 2, 12));    // taken in way 0
				prog.push_back(addi_inst(4, 0, 1));
				prog.push_back(addi_inst(4, 0, 2));
				prog.push_back(addi_inst(5, 0, 3));
				prog.push_back(beq_inst(1, 3, 100));   // falls through
				prog.push_back(beq_inst(0, 0, 12));    // taken in way 2
				prog.push_back(addi_inst(4, 0, 3));
				prog.push_back(addi_inst(4, 0, 4));
				prog.push_back(addi_inst(6, 0, 1));
				prog.push_back(beq_inst(1, 2, 12));    // taken in way 1
				prog.push_back(addi_inst(4, 0, 5));
				prog.push_back(addi_inst(4, 0, 6));
			end
			4: begin
				prog.push_back(addi_inst(1, 0, 1));
				prog.push_back(`WFI_WORD);
				prog.push_back(addi_inst(2, 0, 2));
				prog.push_back(addi_inst(3, 0, 3));
			end
			5: begin
				prog.push_back(addi_inst(1, 0, 1));
				prog.push_back({7'b0, 5'd0, 5'd0, 3'b100, 5'd3, `OPC_OP});    // xor
				prog.push_back(addi_inst(2, 0, 2));
				prog.push_back(addi_inst(4, 0, 4));
			end
			default: ;
		endcase
		prog.push_back(`WFI_WORD);
	endtask

	////////////////////////////////////////
	// sequential ISA model

	task automatic run_model(output status_e status);
		word_t regs [`CORE_REGS];
		addr_t pc;
		addr_t next;
		inst_t inst;
		word_t a;
		word_t b;
		word_t res;
		logic  wen;
		regs = '{default: '0};
		pc = '0;
		status = NO_ERROR;
		exp_pc.delete();
		exp_wen.delete();
		exp_idx.delete();
		exp_data.delete();
		for (int n = 0; n < MEM_WORDS && status == NO_ERROR; n++) begin
			inst = word_at(pc);
			a    = regs[inst[19:15]];
			b    = regs[inst[24:20]];
			res  = '0;
			next = pc + 4;
			case (inst[6:0])
				`OPC_OP: begin
					if (inst[14:12] == 3'b000 && inst[31:25] == 7'h00)
						res = a + b;
					else if (inst[14:12] == 3'b000 && inst[31:25] == 7'h20)
						res = a - b;
					else
						status = ILLEGAL_INST;
				end
				`OPC_OP_IMM: begin
					res = a + {{20{inst[31]}}, inst[31:20]};
					if (inst[14:12] != 3'b000)
						status = ILLEGAL_INST;
				end
				`OPC_BRANCH: begin
					res = word_t'(a == b);
					if (inst[14:12] != 3'b000)
						status = ILLEGAL_INST;
					else if (a == b)
						next = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
							inst[11:8], 1'b0};
				end
				`OPC_SYSTEM: status = (inst == `WFI_WORD) ? HALTED_ON_WFI : ILLEGAL_INST;
				default: status = ILLEGAL_INST;
			endcase
			wen = status == NO_ERROR && inst[11:7] != 5'd0
				&& (inst[6:0] == `OPC_OP || inst[6:0] == `OPC_OP_IMM);
			exp_pc.push_back(pc);
			exp_wen.push_back(wen);
			exp_idx.push_back(inst[11:7]);
			exp_data.push_back(res);
			if (wen)
				regs[inst[11:7]] = res;
			pc = next;
		end
	endtask

	////////////////////////////////////////
	// checks

	task automatic check_value(string name, word_t got, word_t want);
		assert (got == want) else begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
			test_errors++;
		end
	endtask

	// commit ways in way order against the model
	always @(negedge clock) begin
		for (int w = 0; w < 3; w++) begin
			if (commit_valid[w] && exp_pc.size() == 0) begin
				$display("commit at pc %h after the program had stopped", commit_pc[w]);
				test_errors++;
			end else if (commit_valid[w]) begin
				check_value($sformatf("commit_pc[%0d]", w), commit_pc[w], exp_pc[0]);
				check_value($sformatf("commit_wr_en[%0d]", w), word_t'(commit_wr_en[w]),
					word_t'(exp_wen[0]));
				if (exp_wen[0]) begin
					check_value($sformatf("commit_wr_idx[%0d]", w), word_t'(commit_wr_idx[w]),
						word_t'(exp_idx[0]));
					check_value($sformatf("commit_wr_data[%0d]", w), commit_wr_data[w],
						exp_data[0]);
				end
				void'(exp_pc.pop_front());
				void'(exp_wen.pop_front());
				void'(exp_idx.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	task automatic run_test(string name, int id);
		status_e want;
		int      cycles;
		int      fails_before;
		@(posedge clock);
		#1 reset = 1'b0;
		@(posedge clock);
		#1;
		test_errors = 0;
		fails_before = superscalar_core_i.core_assertions_i.failures;
		build_program(id);
		load_memory();
		run_model(want);
		repeat (6) @(posedge clock);
		@(negedge clock);
		check_value("fetch_addr", fetch_addr, '0);    // quiet while in reset
		check_value("commit_valid", word_t'(commit_valid), '0);
		check_value("error_status", word_t'(error_status), word_t'(NO_ERROR));
		@(posedge clock);
		#1 reset = 1'b1;
		cycles = 0;
		while (error_status == NO_ERROR && cycles < 4 * prog.size() + 20) begin
			@(negedge clock);
			cycles++;
		end
		repeat (6) @(negedge clock);    // room for stray commits after the stop
		#2;
		if (error_status == NO_ERROR) begin
			$display("%s: core did not stop within %0d cycles", name, cycles);
			test_errors++;
		end
		check_value("error_status", word_t'(error_status), word_t'(want));
		if (exp_pc.size() != 0) begin
			$display("%s: %0d instructions never committed", name, exp_pc.size());
			test_errors++;
		end
		test_errors += superscalar_core_i.core_assertions_i.failures - fails_before;
		$display("%s: %s", name, test_errors == 0 ? "passed" : "failed");
		errors += test_errors;
		if (test_errors != 0)
			failed_tests++;
	endtask

	initial begin
		void'($urandom(12));
		reset        = 1'b0;
		errors       = 0;
		failed_tests = 0;
		test_errors  = 0;
		load_memory();
		run_test("reset", 0);
		run_test("random", 1);
		run_test("chains", 2);
		run_test("branches", 3);
		run_test("wfi", 4);
		run_test("illegal", 5);
		$display("%0d of %0d tests failed, %0d errors in total", failed_tests, TEST_COUNT, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+logic
logic/core_pkg.sv
logic/fetch_unit.sv
logic/register_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/superscalar_core.sv
tb/core_assertions.sv
tb/core_tb.sv

// File: Makefile
# Verilator build and run of the core testbench
LOG = sim.log

help:
	@echo "targets:"
	@echo "  test   build core_tb with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module core_tb -f verilog.f -o core_tb
	./obj_dir/core_tb +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean
